// ==== src.f ====
+incdir+hdl
hdl/fpu_share_pkg.sv
hdl/fpu_req_if.sv
hdl/fpu_group_arbiter.sv
hdl/fp_sign_unit.sv
hdl/fpu_resp_router.sv
hdl/fpu_share_top.sv
tb/fpu_share_properties.sv
tb/fpu_share_tb.sv

// ==== Makefile ====
# Verilator build and run of the shared FPU cluster testbench

VERILATOR ?= verilator
TOP       ?= fpu_share_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: sim clean

# Builds and runs, exit status follows the testbench result
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)

// ==== tb/fpu_share_tb.sv ====
//////////////////////////////
// Testbench for the shared FPU cluster
// Random stimulus, scoreboard, timeout
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "fpu_share_config.svh"

module fpu_share_tb;

   import fpu_share_pkg::*;

   localparam int NB_CORES   = `FPU_NB_CORES;
   localparam int RESP_LAT   = `FPU_UNIT_STAGES + 1;
   localparam int SIGN_BIT   = `FPU_DATA_WIDTH - 1;
   localparam int MAX_CYCLES = 4000;

   // Request pacing
   localparam int MODE_IDLE   = 0;
   localparam int MODE_SOLO   = 1;
   localparam int MODE_FULL   = 2;
   localparam int MODE_RANDOM = 3;

   logic                    clk;
   logic                    reset_i;
   logic     [NB_CORES-1:0] core_req;
   logic     [NB_CORES-1:0] core_gnt;
   fp_op_t   [NB_CORES-1:0] core_op;
   fp_word_t [NB_CORES-1:0] core_a;
   fp_word_t [NB_CORES-1:0] core_b;
   logic     [NB_CORES-1:0] core_rvalid;
   fp_word_t [NB_CORES-1:0] core_rdata;

   logic     [NB_CORES-1:0] accepted;
   int                      cycle = 0;
   int                      mode;
   int                      solo_core;
   int                      issued [NB_CORES];

   // Expected results per core in issue order
   fp_word_t exp_data_q  [NB_CORES][$];
   int       exp_cycle_q [NB_CORES][$];

   fpu_share_top fpu_share_top_i
   (
      .clk              ( clk         ),
      .reset_i          ( reset_i     ),
      .core_req_i       ( core_req    ),
      .core_gnt_o       ( core_gnt    ),
      .core_op_i        ( core_op     ),
      .core_operand_a_i ( core_a      ),
      .core_operand_b_i ( core_b      ),
      .core_rvalid_o    ( core_rvalid ),
      .core_rdata_o     ( core_rdata  )
   );

   always #4 clk = ~clk;

   task automatic stop_with_failure(input string reason);
      $display("%s", reason);
      $display("Test failed");
      $fatal(1, "Simulation stopped on a check");
   endtask

   always @(posedge clk)
   begin
      cycle <= cycle + 1;
      if (cycle >= MAX_CYCLES)
         stop_with_failure($sformatf("Timeout, run did not end within %0d cycles", MAX_CYCLES));
   end

   //////////////////////////////
   // Reference model and helpers
   //////////////////////////////
   function automatic fp_word_t expected_result(fp_op_t op, fp_word_t a, fp_word_t b);
      fp_word_t res;
      res = a;
      if (op == OP_SGNJ)
         res[SIGN_BIT] = b[SIGN_BIT];
      else if (op == OP_SGNJN)
         res[SIGN_BIT] = ~b[SIGN_BIT];
      else if (op == OP_SGNJX)
         res[SIGN_BIT] = a[SIGN_BIT] ^ b[SIGN_BIT];
      return res;
   endfunction

   function automatic int outstanding();
      int n;
      n = 0;
      for (int c = 0; c < NB_CORES; c++)
         n += exp_data_q[c].size();
      return n;
   endfunction

   function automatic bit wants_request(int c);
      logic [31:0] r;
      case (mode)
         MODE_SOLO:   return c == solo_core;
         MODE_FULL:   return 1'b1;
         MODE_RANDOM:
         begin
            r = $urandom();
            return r[0];
         end
         default:     return 1'b0;
      endcase
   endfunction

   task automatic load_request(int c);
      fp_word_t    ra;
      fp_word_t    rb;
      logic [31:0] rop;
      ra  = $urandom();
      rb  = $urandom();
      rop = $urandom();
      // First 16 requests of a core walk every op and sign pair
      if (issued[c] < 16)
      begin
         rop          = 32'(issued[c]);
         ra[SIGN_BIT] = rop[2];
         rb[SIGN_BIT] = rop[3];
      end
      core_req[c] = 1'b1;
      core_op[c]  = fp_op_t'(rop[`FPU_OP_WIDTH-1:0]);
      core_a[c]   = ra;
      core_b[c]   = rb;
      issued[c]++;
   endtask

   task automatic check_response(int c);
      fp_word_t exp_data;
      int       exp_cycle;
      assert (exp_data_q[c].size() > 0)
      else stop_with_failure($sformatf("core_rvalid_o[%0d] pulsed with no request open", c));
      exp_data  = exp_data_q[c].pop_front();
      exp_cycle = exp_cycle_q[c].pop_front();
      // Pulse driven after edge E + RESP_LAT - 1 and sampled at edge E + RESP_LAT
      assert (cycle == exp_cycle + RESP_LAT - 1)
      else stop_with_failure($sformatf("ERR t=%0t core_rvalid_o[%0d] cycle expected %0d got %0d",
                                       $time, c, exp_cycle + RESP_LAT - 1, cycle));
      assert (core_rdata[c] == exp_data)
      else stop_with_failure($sformatf("ERR t=%0t core_rdata_o[%0d] expected %h got %h",
                                       $time, c, exp_data, core_rdata[c]));
   endtask

   //////////////////////////////
   // One clock cycle from falling edge to falling edge
   //////////////////////////////
   task automatic run_cycle();
      for (int c = 0; c < NB_CORES; c++)
         if (core_rvalid[c])
            check_response(c);
      assert (!fpu_share_top_i.fpu_share_properties_i.any_violation)
      else stop_with_failure("A protocol assertion on the DUT fired");
      for (int c = 0; c < NB_CORES; c++)
      begin
         if (core_req[c] && accepted[c])
            core_req[c] = 1'b0;
         if (!core_req[c] && wants_request(c))
            load_request(c);
      end
      // Grant seen here is the one taken at the coming edge
      #1;
      for (int c = 0; c < NB_CORES; c++)
      begin
         accepted[c] = core_req[c] && core_gnt[c];
         if (accepted[c])
         begin
            exp_data_q[c].push_back(expected_result(core_op[c], core_a[c], core_b[c]));
            exp_cycle_q[c].push_back(cycle + 1);
         end
      end
      @(negedge clk);
   endtask

   task automatic run_cycles(int n);
      repeat (n)
         run_cycle();
   endtask

   initial
   begin
      void'($urandom(32'h025b5f47));
      clk       = 1'b0;
      reset_i   = 1'b1;
      core_req  = '0;
      core_op   = '0;
      core_a    = '0;
      core_b    = '0;
      accepted  = '0;
      mode      = MODE_IDLE;
      solo_core = 0;
      for (int c = 0; c < NB_CORES; c++)
         issued[c] = 0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      reset_i = 1'b0;

      // Quiet after reset
      run_cycles(5);

      // One core at a time with back-to-back requests
      mode = MODE_SOLO;
      for (int c = 0; c < NB_CORES; c++)
      begin
         solo_core = c;
         run_cycles(16);
      end

      // Whole groups busy and then random load
      mode = MODE_FULL;
      run_cycles(200);
      mode = MODE_RANDOM;
      run_cycles(400);

      mode = MODE_IDLE;
      while (outstanding() != 0 || |core_req)
         run_cycle();
      run_cycles(8);

      if (!fpu_share_top_i.fpu_share_properties_i.any_violation)
      begin
         $display("Test completed successfully");
         $finish;
      end
      else
         stop_with_failure("A protocol assertion on the DUT fired");
   end

endmodule

`default_nettype wire

// ==== tb/fpu_share_properties.sv ====
//////////////////////////////
// Protocol and timing assertions
// Bound to the shared FPU top level
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "fpu_share_config.svh"

module fpu_share_properties
(
   input  logic                     clk,
   input  logic                     reset_i,
   input  logic [`FPU_NB_CORES-1:0] core_req_i,
   input  logic [`FPU_NB_CORES-1:0] core_gnt_i,
   input  logic [`FPU_NB_CORES-1:0] core_rvalid_i
);

   // Accepting edge to the edge that samples the response pulse
   localparam int RESP_LAT = `FPU_UNIT_STAGES + 1;

   // Cores served by one unit
   function automatic logic [`FPU_NB_CORES-1:0] member_mask(int unit);
      logic [`FPU_NB_CORES-1:0] mask;
      mask = '0;
      for (int c = 0; c < `FPU_NB_CORES; c++)
         if (c % `FPU_NB_UNITS == unit)
            mask[c] = 1'b1;
      return mask;
   endfunction

   logic [`FPU_NB_UNITS-1:0] grp_req;
   logic [`FPU_NB_UNITS-1:0] grp_gnt;
   logic [`FPU_NB_UNITS-1:0] grp_multi;
   logic [`FPU_NB_UNITS-1:0] grp_busy;
   logic [`FPU_NB_UNITS-1:0] grp_repeat;
   logic [`FPU_NB_UNITS-1:0] prev_busy;
   logic [`FPU_NB_CORES-1:0] prev_gnt;

   // Sticky failure flag per assertion
   logic latency_bad = 1'b0;
   logic stray_gnt   = 1'b0;
   logic group_bad   = 1'b0;
   logic rr_bad      = 1'b0;
   logic reset_bad   = 1'b0;
   logic any_violation;

   assign any_violation = latency_bad | stray_gnt | group_bad | rr_bad | reset_bad;

   for (genvar u = 0; u < `FPU_NB_UNITS; u++)
   begin : gen_group
      localparam logic [`FPU_NB_CORES-1:0] MASK = member_mask(u);
      assign grp_req[u]    = |(core_req_i & MASK);
      assign grp_gnt[u]    = |(core_gnt_i & MASK);
      assign grp_multi[u]  = !$onehot0(core_gnt_i & MASK);
      assign grp_busy[u]   = ((core_req_i & MASK) == MASK);
      assign grp_repeat[u] = ((core_gnt_i & MASK) == (prev_gnt & MASK));
   end

   // Grant history for the round-robin check
   always_ff @(posedge clk)
   begin
      if (reset_i)
         prev_busy <= '0;
      else
         prev_busy <= grp_busy;
      prev_gnt <= core_gnt_i;
   end

   //////////////////////////////
   // Assertions
   //////////////////////////////
   rvalid_latency_a : assert property (@(posedge clk) disable iff (reset_i)
      core_rvalid_i == $past(core_gnt_i, RESP_LAT))
   else
   begin
      latency_bad = 1'b1;
      $error("Response pulse does not match the grant %0d edges earlier", RESP_LAT);
   end

   gnt_needs_req_a : assert property (@(posedge clk) disable iff (reset_i)
      (core_gnt_i & ~core_req_i) == '0)
   else
   begin
      stray_gnt = 1'b1;
      $error("Grant given to a core without a request");
   end

   // One grant per group and every requesting group served
   group_grant_a : assert property (@(posedge clk) disable iff (reset_i)
      (grp_multi == '0) && (grp_gnt == grp_req))
   else
   begin
      group_bad = 1'b1;
      $error("Group grant count wrong, req %b gnt %b", grp_req, grp_gnt);
   end

   round_robin_a : assert property (@(posedge clk) disable iff (reset_i)
      (grp_busy & prev_busy & grp_repeat) == '0)
   else
   begin
      rr_bad = 1'b1;
      $error("Same member granted twice while the whole group requests");
   end

   reset_quiet_a : assert property (@(posedge clk)
      $past(reset_i) |-> (core_rvalid_i == '0))
   else
   begin
      reset_bad = 1'b1;
      $error("Response pulse right after reset");
   end

endmodule

bind fpu_share_top fpu_share_properties fpu_share_properties_i
(
   .clk           ( clk           ),
   .reset_i       ( reset_i       ),
   .core_req_i    ( core_req_i    ),
   .core_gnt_i    ( core_gnt_o    ),
   .core_rvalid_i ( core_rvalid_o )
);

`default_nettype wire

// ==== hdl/fpu_share_top.sv ====
//////////////////////////////
// Shared FPU cluster top level
// Group arbiters, sign units, response router
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "fpu_share_config.svh"

module fpu_share_top
(
   input  logic                                          clk,
   input  logic                                          reset_i,

   // Core request side
   input  logic [`FPU_NB_CORES-1:0]                      core_req_i,
   output logic [`FPU_NB_CORES-1:0]                      core_gnt_o,
   input  fpu_share_pkg::fp_op_t   [`FPU_NB_CORES-1:0]   core_op_i,
   input  fpu_share_pkg::fp_word_t [`FPU_NB_CORES-1:0]   core_operand_a_i,
   input  fpu_share_pkg::fp_word_t [`FPU_NB_CORES-1:0]   core_operand_b_i,

   // Core response side, no back-pressure
   output logic [`FPU_NB_CORES-1:0]                      core_rvalid_o,
   output fpu_share_pkg::fp_word_t [`FPU_NB_CORES-1:0]   core_rdata_o
);

   import fpu_share_pkg::*;

   // Grant vectors, one per arbiter
   logic [`FPU_NB_UNITS-1:0][`FPU_NB_CORES-1:0] s_arb_gnt;

   // Unit results towards the router
   logic     [`FPU_NB_UNITS-1:0] s_res_valid;
   core_id_t [`FPU_NB_UNITS-1:0] s_res_id;
   fp_word_t [`FPU_NB_UNITS-1:0] s_res_data;

   //////////////////////////////
   // One arbiter and one unit per group
   //////////////////////////////
   for (genvar u = 0; u < `FPU_NB_UNITS; u++)
   begin : gen_unit
      fpu_req_if s_req_if ();

      fpu_group_arbiter
      #(
         .UNIT_INDEX       ( u                 )
      )
      i_fpu_group_arbiter
      (
         .clk              ( clk               ),
         .reset_i          ( reset_i           ),
         .core_req_i       ( core_req_i        ),
         .core_op_i        ( core_op_i         ),
         .core_operand_a_i ( core_operand_a_i  ),
         .core_operand_b_i ( core_operand_b_i  ),
         .core_gnt_o       ( s_arb_gnt[u]      ),
         .req_if           ( s_req_if          )
      );

      fp_sign_unit i_fp_sign_unit
      (
         .clk              ( clk               ),
         .reset_i          ( reset_i           ),
         .req_if           ( s_req_if          ),
         .res_valid_o      ( s_res_valid[u]    ),
         .res_id_o         ( s_res_id[u]       ),
         .res_data_o       ( s_res_data[u]     )
      );
   end

   // Each core listens to the arbiter of its own group
   for (genvar c = 0; c < `FPU_NB_CORES; c++)
   begin : gen_core_gnt
      assign core_gnt_o[c] = s_arb_gnt[c % `FPU_NB_UNITS][c];
   end

   //////////////////////////////
   // Response routing
   //////////////////////////////
   fpu_resp_router i_fpu_resp_router
   (
      .clk              ( clk               ),
      .reset_i          ( reset_i           ),
      .res_valid_i      ( s_res_valid       ),
      .res_id_i         ( s_res_id          ),
      .res_data_i       ( s_res_data        ),
      .core_rvalid_o    ( core_rvalid_o     ),
      .core_rdata_o     ( core_rdata_o      )
   );

endmodule

`default_nettype wire

// ==== hdl/fpu_resp_router.sv ====
//////////////////////////////
// Registered routing of unit results to cores
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "fpu_share_config.svh"

module fpu_resp_router
(
   input  logic                                          clk,
   input  logic                                          reset_i,

   input  logic [`FPU_NB_UNITS-1:0]                      res_valid_i,
   input  fpu_share_pkg::core_id_t [`FPU_NB_UNITS-1:0]   res_id_i,
   input  fpu_share_pkg::fp_word_t [`FPU_NB_UNITS-1:0]   res_data_i,

   output logic [`FPU_NB_CORES-1:0]                      core_rvalid_o,
   output fpu_share_pkg::fp_word_t [`FPU_NB_CORES-1:0]   core_rdata_o
);

   import fpu_share_pkg::*;

   // Result of the core's own unit is addressed to it
   logic [`FPU_NB_CORES-1:0] hit;

   // Core c is only ever served by unit c mod NB_UNITS
   always_comb
   begin
      for (int c = 0; c < `FPU_NB_CORES; c++)
         hit[c] = res_valid_i[c % `FPU_NB_UNITS]
                  && (res_id_i[c % `FPU_NB_UNITS] == core_id_t'(c));
   end

   // One-cycle response pulse
   always_ff @(posedge clk)
   begin
      if (reset_i)
         core_rvalid_o <= '0;
      else
         core_rvalid_o <= hit;
   end

   // Data holds until the next result for that core
   always_ff @(posedge clk)
   begin
      for (int c = 0; c < `FPU_NB_CORES; c++)
      begin
         if (hit[c])
            core_rdata_o[c] <= res_data_i[c % `FPU_NB_UNITS];
      end
   end

endmodule

`default_nettype wire

// ==== hdl/fp_sign_unit.sv ====
//////////////////////////////
// Pipelined FP sign-operation unit
// Core ID travels with each result
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "fpu_share_config.svh"

module fp_sign_unit
(
   input  logic                     clk,
   input  logic                     reset_i,

   fpu_req_if.unit                  req_if,

   output logic                     res_valid_o,
   output fpu_share_pkg::core_id_t  res_id_o,
   output fpu_share_pkg::fp_word_t  res_data_o
);

   import fpu_share_pkg::*;

   localparam int STAGES   = `FPU_UNIT_STAGES;
   localparam int SIGN_BIT = `FPU_DATA_WIDTH - 1;

   fp_word_t result;
   logic     sign_res;

   logic     [STAGES-1:0] valid_q;
   core_id_t [STAGES-1:0] id_q;
   fp_word_t [STAGES-1:0] data_q;

   //////////////////////////////
   // Sign operation, first stage
   //////////////////////////////
   always_comb
   begin
      case (req_if.op)
         OP_SGNJ:  sign_res = req_if.operand_b[SIGN_BIT];
         OP_SGNJN: sign_res = ~req_if.operand_b[SIGN_BIT];
         OP_SGNJX: sign_res = req_if.operand_a[SIGN_BIT] ^ req_if.operand_b[SIGN_BIT];
         default:  sign_res = req_if.operand_a[SIGN_BIT];
      endcase
      result = {sign_res, req_if.operand_a[SIGN_BIT-1:0]};
   end

   // Valid chain
   always_ff @(posedge clk)
   begin
      if (reset_i)
         valid_q <= '0;
      else
      begin
         valid_q[0] <= req_if.valid;
         for (int s = 1; s < STAGES; s++)
            valid_q[s] <= valid_q[s-1];
      end
   end

   // Payload moves only along with a valid
   always_ff @(posedge clk)
   begin
      if (req_if.valid)
      begin
         id_q[0]   <= req_if.id;
         data_q[0] <= result;
      end
      for (int s = 1; s < STAGES; s++)
      begin
         if (valid_q[s-1])
         begin
            id_q[s]   <= id_q[s-1];
            data_q[s] <= data_q[s-1];
         end
      end
   end

   assign res_valid_o = valid_q[STAGES-1];
   assign res_id_o    = id_q[STAGES-1];
   assign res_data_o  = data_q[STAGES-1];

endmodule

`default_nettype wire

// ==== hdl/fpu_group_arbiter.sv ====
//////////////////////////////
// Round-robin arbiter for one core group
// Grants one request per cycle, tags it with the core ID
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "fpu_share_config.svh"

module fpu_group_arbiter
#(
   parameter int UNIT_INDEX = 0
)
(
   input  logic                                          clk,
   input  logic                                          reset_i,

   input  logic [`FPU_NB_CORES-1:0]                      core_req_i,
   input  fpu_share_pkg::fp_op_t   [`FPU_NB_CORES-1:0]   core_op_i,
   input  fpu_share_pkg::fp_word_t [`FPU_NB_CORES-1:0]   core_operand_a_i,
   input  fpu_share_pkg::fp_word_t [`FPU_NB_CORES-1:0]   core_operand_b_i,
   output logic [`FPU_NB_CORES-1:0]                      core_gnt_o,

   fpu_req_if.arb                                        req_if
);

   import fpu_share_pkg::*;

   localparam int PTR_WIDTH = (GROUP_SIZE > 1) ? $clog2(GROUP_SIZE) : 1;

   // Group members, member m is core UNIT_INDEX + m * NB_UNITS
   logic     [GROUP_SIZE-1:0] member_req;
   fp_op_t   [GROUP_SIZE-1:0] member_op;
   fp_word_t [GROUP_SIZE-1:0] member_a;
   fp_word_t [GROUP_SIZE-1:0] member_b;
   core_id_t [GROUP_SIZE-1:0] member_id;
   logic     [GROUP_SIZE-1:0] gnt_member;

   // Member with highest priority this cycle
   logic [PTR_WIDTH-1:0] ptr_q;
   logic [PTR_WIDTH-1:0] winner;
   logic                 gnt_found;

   for (genvar m = 0; m < GROUP_SIZE; m++)
   begin : gen_member
      assign member_req[m] = core_req_i[UNIT_INDEX + m * `FPU_NB_UNITS];
      assign member_op[m]  = core_op_i[UNIT_INDEX + m * `FPU_NB_UNITS];
      assign member_a[m]   = core_operand_a_i[UNIT_INDEX + m * `FPU_NB_UNITS];
      assign member_b[m]   = core_operand_b_i[UNIT_INDEX + m * `FPU_NB_UNITS];
      assign member_id[m]  = core_id_t'(UNIT_INDEX + m * `FPU_NB_UNITS);
   end

   //////////////////////////////
   // Priority search from the pointer, wrapping around the group
   //////////////////////////////
   always_comb
   begin
      int cand;
      gnt_found = 1'b0;
      winner    = ptr_q;
      for (int k = 0; k < GROUP_SIZE; k++)
      begin
         cand = int'(ptr_q) + k;
         if (cand >= GROUP_SIZE)
            cand = cand - GROUP_SIZE;
         if (!gnt_found && member_req[cand])
         begin
            gnt_found = 1'b1;
            winner    = PTR_WIDTH'(cand);
         end
      end
      for (int m = 0; m < GROUP_SIZE; m++)
         gnt_member[m] = gnt_found && (winner == PTR_WIDTH'(m));
   end

   // Pointer moves past the granted member
   always_ff @(posedge clk)
   begin
      if (reset_i)
         ptr_q <= '0;
      else if (gnt_found)
      begin
         if (winner == PTR_WIDTH'(GROUP_SIZE - 1))
            ptr_q <= '0;
         else
            ptr_q <= winner + 1'b1;
      end
   end

   // Only this group's cores get a grant from here
   for (genvar c = 0; c < `FPU_NB_CORES; c++)
   begin : gen_gnt
      if (c % `FPU_NB_UNITS == UNIT_INDEX)
      begin : gen_own
         assign core_gnt_o[c] = gnt_member[c / `FPU_NB_UNITS];
      end
      else
      begin : gen_other
         assign core_gnt_o[c] = 1'b0;
      end
   end

   // Granted request towards the unit
   assign req_if.valid     = gnt_found;
   assign req_if.id        = member_id[winner];
   assign req_if.op        = member_op[winner];
   assign req_if.operand_a = member_a[winner];
   assign req_if.operand_b = member_b[winner];

endmodule

`default_nettype wire

// ==== hdl/fpu_req_if.sv ====
//////////////////////////////
// Granted request, arbiter to unit
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface fpu_req_if;

   import fpu_share_pkg::*;

   // Strobe, high in each cycle a grant is given
   logic     valid;

   // Core that owns the request
   core_id_t id;

   // Operation and operands
   fp_op_t   op;
   fp_word_t operand_a;
   fp_word_t operand_b;

   // Arbiter side drives everything
   modport arb  (output valid, output id, output op, output operand_a, output operand_b);

   // Unit side, always accepts
   modport unit (input valid, input id, input op, input operand_a, input operand_b);

endinterface

`default_nettype wire

// ==== hdl/fpu_share_pkg.sv ====
//////////////////////////////
// Shared types and sign-op codes
//////////////////////////////

`default_nettype none

`include "fpu_share_config.svh"

package fpu_share_pkg;

   // Single-precision word, bit 31 is the sign
   typedef logic [`FPU_DATA_WIDTH-1:0]       fp_word_t;

   // Sign-operation code
   typedef logic [`FPU_OP_WIDTH-1:0]         fp_op_t;

   // Index of the requesting core
   typedef logic [$clog2(`FPU_NB_CORES)-1:0] core_id_t;

   // Magnitude of a, sign taken from b
   localparam fp_op_t OP_SGNJ  = fp_op_t'(0);
   // Magnitude of a, inverted sign of b
   localparam fp_op_t OP_SGNJN = fp_op_t'(1);
   // Magnitude of a, sign a xor sign b
   localparam fp_op_t OP_SGNJX = fp_op_t'(2);
   // Plain move of a
   localparam fp_op_t OP_FMV   = fp_op_t'(3);

   // Cores sharing one unit
   localparam int GROUP_SIZE = `FPU_NB_CORES / `FPU_NB_UNITS;

endpackage

`default_nettype wire

// ==== hdl/fpu_share_config.svh ====
//////////////////////////////
// Build macros for the shared FPU cluster
// Core count, unit count, widths, pipeline depth
//////////////////////////////

`ifndef FPU_SHARE_CONFIG_SVH
`define FPU_SHARE_CONFIG_SVH

// Cores and shared units, units must divide cores
`define FPU_NB_CORES     4
`define FPU_NB_UNITS     2

// Datapath widths
`define FPU_DATA_WIDTH   32
`define FPU_OP_WIDTH     2

// Register stages inside one sign unit
`define FPU_UNIT_STAGES  2

`endif
